/* hw/uopPkg.sv */
// Micro-op expander shared definitions

package uopPkg;

	// Word and field types
	typedef logic [31:0] instrWord; // Instruction or micro-op word
	typedef logic [3:0] regIdx; // Register number
	typedef logic [15:0] regMask; // LDM register list, bit i is Ri
	typedef logic [3:0] condFlags; // NZCV, N in bit 3
	typedef logic [3:0] rzSelect; // {RA1 mux, WA3 bank, RA2 bank, RA1 bank}
	typedef logic [11:0] offset12; // Immediate load offset

	// Expansion kind picked by the classifier
	typedef enum logic [2:0] {
		kindNone, // Pass through unchanged
		kindRsr, // Register-shifted-register data processing
		kindMulAcc, // Short multiply-accumulate
		kindBranchLink, // BL split into MOV LR and B
		kindLoadMultiple // LDM split into single loads
	} uopKind;

	// Sequencer states, one per expansion after its first step
	typedef enum logic [2:0] {
		stReady, // Between instructions
		stRsr, // Second RSR step pending
		stMulAcc, // ADD step of MLA pending
		stBranchLink, // Branch step of BL pending
		stLoadMultiple // Later LDM loads pending
	} seqState;

	// Data-processing opcodes
	localparam logic [3:0] opMov = 4'b1101;
	localparam logic [3:0] opAdd = 4'b0100;

	// Register numbers
	localparam logic [3:0] regRz = 4'd15; // Scratch register, upper bank
	localparam logic [3:0] regLink = 4'd14;
	localparam logic [3:0] regPc = 4'd15;

	// Address step between consecutive LDM words
	localparam logic [11:0] wordBytes = 12'd4;

endpackage

/* hw/condCheck.sv */
// Condition code evaluation

`timescale 1ns/1ps

module condCheck (
	input uopPkg::instrWord instr, // Condition taken from bits 31:28
	input uopPkg::condFlags flags, // Current NZCV
	output logic condPass // Instruction would execute
);

	logic n, z, c, v;

	assign n = flags[3];
	assign z = flags[2];
	assign c = flags[1];
	assign v = flags[0];

	always_comb begin
		case (instr[31:28])
			4'b0000: condPass = z; // EQ
			4'b0001: condPass = ~z; // NE
			4'b0010: condPass = c; // CS/HS
			4'b0011: condPass = ~c; // CC/LO
			4'b0100: condPass = n; // MI
			4'b0101: condPass = ~n; // PL
			4'b0110: condPass = v; // VS
			4'b0111: condPass = ~v; // VC
			4'b1000: condPass = c & ~z; // HI
			4'b1001: condPass = ~c | z; // LS
			4'b1010: condPass = (n == v); // GE
			4'b1011: condPass = (n != v); // LT
			4'b1100: condPass = ~z & (n == v); // GT
			4'b1101: condPass = z | (n != v); // LE
			4'b1110: condPass = 1'b1; // AL
			default: condPass = 1'b0; // Never code
		endcase
	end

endmodule

/* hw/uopClassify.sv */
// Expansion kind decoder

`timescale 1ns/1ps

module uopClassify (
	input uopPkg::instrWord instr, // Instruction in decode
	output uopPkg::uopKind kind // Which expansion applies
);

	logic isBx; // Branch-exchange shares the RSR encoding space
	logic isRsr;
	logic isMulAcc;
	logic isBranchLink;
	logic isLoadMultiple;

	// BX is 0001_0010 then SBO nibbles then 0001
	assign isBx = (instr[27:4] == {8'b0001_0010, 12'hFFF, 4'b0001});

	// Data processing, register operand shifted by a register
	assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4] && !isBx;

	// MLA only, long forms have bit 23 set
	assign isMulAcc = (instr[27:24] == 4'b0000) && !instr[23] && instr[21]
		&& (instr[7:4] == 4'b1001);

	assign isBranchLink = (instr[27:24] == 4'b1011); // B with L bit

	// LDM with at least one register in the list
	assign isLoadMultiple = (instr[27:25] == 3'b100) && instr[20]
		&& (instr[15:0] != 16'h0000);

	// Checks run in priority order
	always_comb begin
		if (isRsr) begin
			kind = uopPkg::kindRsr;
		end else if (isMulAcc) begin
			kind = uopPkg::kindMulAcc;
		end else if (isBranchLink) begin
			kind = uopPkg::kindBranchLink;
		end else if (isLoadMultiple) begin
			kind = uopPkg::kindLoadMultiple;
		end else begin
			kind = uopPkg::kindNone;
		end
	end

endmodule

/* hw/ldmRegList.sv */
// Load-multiple register list

`timescale 1ns/1ps

module ldmRegList (
	input logic clk,
	input logic reset,
	input logic stall, // Hold list and step index
	input uopPkg::instrWord instr, // LDM held in decode
	input logic listStart, // First LDM step, list comes from instr
	input logic listAdvance, // Later LDM step, list comes from heldList
	output uopPkg::regIdx ldmReg, // Lowest register still to load
	output uopPkg::offset12 ldmOffset, // Address delta magnitude
	output logic ldmUp, // Delta is nonnegative
	output logic ldmLast // Only ldmReg remains
);

	uopPkg::regMask heldList; // Registers left after the current step
	uopPkg::regMask curList; // Registers left including the current one
	uopPkg::regMask nextList; // curList without its lowest register
	logic [3:0] stepIdx; // Loads already issued
	logic [3:0] curStep;
	logic [4:0] regCount; // Registers in the whole LDM, 1 to 16
	logic signed [12:0] listBytes;
	logic signed [12:0] firstDelta; // Delta of the first load from Rn
	logic signed [12:0] delta;
	logic signed [12:0] magnitude;

	assign curList = listStart ? instr[15:0] : heldList; // Fresh list in start cycle
	assign curStep = listStart ? 4'd0 : stepIdx;
	assign nextList = curList & (curList - 16'd1); // Clear lowest set bit
	assign ldmLast = (nextList == '0);

	// Lowest set bit wins, so scan downward
	always_comb begin
		ldmReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (curList[i]) ldmReg = 4'(i);
		end
	end

	assign regCount = 5'($countones(instr[15:0]));
	assign listBytes = uopPkg::wordBytes * regCount; // 4n

	always_comb begin
		case (instr[24:23]) // P and U bits
			2'b00: firstDelta = uopPkg::wordBytes - listBytes; // DA, Rn + 4 - 4n
			2'b01: firstDelta = '0; // IA
			2'b10: firstDelta = -listBytes; // DB
			default: firstDelta = uopPkg::wordBytes; // IB
		endcase
	end

	assign delta = firstDelta + uopPkg::wordBytes * curStep; // Walks upward 4 bytes per load
	assign magnitude = delta[12] ? -delta : delta;
	assign ldmUp = ~delta[12];
	assign ldmOffset = magnitude[11:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			heldList <= '0; // Empty list
			stepIdx <= '0;
		end else if (!stall && (listStart || listAdvance)) begin
			heldList <= nextList; // Drop the register just loaded
			stepIdx <= curStep + 4'd1;
		end
	end

	// Classifier only starts nonempty lists, sequencer stops at the last one
	listNotEmpty: assert property (@(posedge clk) disable iff (reset)
		(listStart || listAdvance) |-> (curList != '0));

	// Held list only keeps registers from the LDM's own list
	regInList: assert property (@(posedge clk) disable iff (reset)
		listAdvance |-> instr[ldmReg]);

endmodule

/* hw/uopSequencer.sv */
// Micro-op sequencer FSM

`timescale 1ns/1ps

module uopSequencer (
	input logic clk,
	input logic reset,
	input logic stall, // Pipeline held, repeat this step
	input uopPkg::instrWord instr, // Held in decode during the expansion
	input uopPkg::uopKind kind,
	input logic condPass, // LDM condition under current flags
	input uopPkg::regIdx ldmReg,
	input uopPkg::offset12 ldmOffset,
	input logic ldmUp,
	input logic ldmLast,
	output logic listStart,
	output logic listAdvance,
	output logic useUop, // Select uopInstr over instr
	output logic uopStall, // Hold fetch, more steps follow
	output logic noFlagUpdate,
	output logic keepV, // Multiplier leaves V alone
	output logic prevRsr, // Second step consumes Rz result
	output logic ldmForward, // Forward the previous load's base
	output uopPkg::instrWord uopInstr,
	output uopPkg::rzSelect rz
);

	uopPkg::seqState state, nextState;
	uopPkg::instrWord ldmWord; // Single load for the current LDM register

	// LDR Rd, [Rn, #+/-offset], pre-indexed, no writeback
	assign ldmWord = {instr[31:28], // Cond
		3'b010, // Immediate single transfer
		1'b1, // P, pre-index
		ldmUp, // U
		1'b0, // B, word
		1'b0, // W, base untouched
		1'b1, // L
		instr[19:16], // Rn
		ldmReg, // Rd
		ldmOffset};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopPkg::stReady;
		end else if (!stall) begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		useUop = 1'b0;
		uopStall = 1'b0;
		noFlagUpdate = 1'b0;
		keepV = 1'b0;
		prevRsr = 1'b0;
		ldmForward = 1'b0;
		listStart = 1'b0;
		listAdvance = 1'b0;
		rz = 4'b0000;
		uopInstr = instr; // Pass-through by default
		case (state)
			uopPkg::stReady: begin
				case (kind)
					uopPkg::kindRsr: begin // MOV Rz, Rm shift Rs
						useUop = 1'b1;
						uopStall = 1'b1;
						noFlagUpdate = 1'b1;
						rz = 4'b1100; // Write Rz in upper bank
						uopInstr = {instr[31:25], uopPkg::opMov, 1'b0, 4'b0000, uopPkg::regRz,
							instr[11:0]};
						nextState = uopPkg::stRsr;
					end
					uopPkg::kindMulAcc: begin // MUL Rz, Rm, Rs
						useUop = 1'b1;
						uopStall = 1'b1;
						keepV = 1'b1;
						rz = 4'b1100;
						uopInstr = {instr[31:24], 1'b0, instr[22], 1'b0, 1'b0, uopPkg::regRz,
							4'b0000, instr[11:0]};
						nextState = uopPkg::stMulAcc;
					end
					uopPkg::kindBranchLink: begin // MOV LR, PC
						useUop = 1'b1;
						uopStall = 1'b1;
						uopInstr = {instr[31:28], 3'b000, uopPkg::opMov, 1'b0, 4'b0000,
							uopPkg::regLink, 8'h00, uopPkg::regPc};
						nextState = uopPkg::stBranchLink;
					end
					uopPkg::kindLoadMultiple: begin
						// First load needs no condition check
						useUop = 1'b1;
						uopStall = !ldmLast;
						noFlagUpdate = 1'b1;
						listStart = 1'b1;
						uopInstr = ldmWord;
						nextState = ldmLast ? uopPkg::stReady : uopPkg::stLoadMultiple;
					end
					default: begin
						nextState = uopPkg::stReady;
					end
				endcase
			end
			uopPkg::stRsr: begin // Original op with Rz as plain operand
				useUop = 1'b1;
				prevRsr = 1'b1;
				rz = 4'b0010; // Read RA2 from upper bank
				uopInstr = {instr[31:12], 8'h00, uopPkg::regRz};
				nextState = uopPkg::stReady;
			end
			uopPkg::stMulAcc: begin // ADD Rd, Rz, Rn
				useUop = 1'b1;
				prevRsr = 1'b1;
				rz = 4'b0001; // Read RA1 from upper bank
				uopInstr = {instr[31:28], 3'b000, uopPkg::opAdd, instr[20], uopPkg::regRz,
					instr[19:16], 8'h00, instr[15:12]};
				nextState = uopPkg::stReady;
			end
			uopPkg::stBranchLink: begin
				useUop = 1'b1;
				uopInstr = {instr[31:25], 1'b0, instr[23:0]}; // Plain B
				nextState = uopPkg::stReady;
			end
			uopPkg::stLoadMultiple: begin
				useUop = 1'b1;
				noFlagUpdate = 1'b1;
				ldmForward = 1'b1;
				listAdvance = 1'b1;
				if (!condPass) begin
					// Condition failed, squash with a NOP and stop
					uopInstr = {instr[31:28], 3'b001, uopPkg::opAdd, 21'h000000};
					nextState = uopPkg::stReady;
				end else begin
					uopStall = !ldmLast;
					uopInstr = ldmWord;
					nextState = ldmLast ? uopPkg::stReady : uopPkg::stLoadMultiple;
				end
			end
			default: begin
				nextState = uopPkg::stReady;
			end
		endcase
	end

	// Instruction stays in decode for the whole expansion
	heldInstrExpands: assert property (@(posedge clk) disable iff (reset)
		(state != uopPkg::stReady) |-> (kind != uopPkg::kindNone));

	// Final step of any expansion returns to stReady
	finalStepIdle: assert property (@(posedge clk) disable iff (reset)
		(useUop && !uopStall && !stall) |=> (state == uopPkg::stReady));

endmodule

/* hw/uopExpander.sv */
// Micro-op expander top

`timescale 1ns/1ps

module uopExpander (
	input logic clk,
	input logic reset,
	input uopPkg::instrWord instr, // Instruction in decode
	input uopPkg::condFlags flags, // Current NZCV
	input logic stall, // Pipeline stalled
	output logic useUop,
	output uopPkg::instrWord uopInstr,
	output logic uopStall, // Hold fetch
	output logic noFlagUpdate,
	output logic keepV,
	output logic prevRsr,
	output logic ldmForward,
	output uopPkg::rzSelect rz
);

	uopPkg::uopKind kind;
	logic condPass;
	logic listStart, listAdvance;
	uopPkg::regIdx ldmReg;
	uopPkg::offset12 ldmOffset;
	logic ldmUp, ldmLast;

	condCheck condCheckInst (.instr(instr), .flags(flags), .condPass(condPass));

	uopClassify classifyInst (.instr(instr), .kind(kind));

	ldmRegList regListInst (.clk(clk), .reset(reset), .stall(stall), .instr(instr),
		.listStart(listStart), .listAdvance(listAdvance), .ldmReg(ldmReg),
		.ldmOffset(ldmOffset), .ldmUp(ldmUp), .ldmLast(ldmLast));

	uopSequencer sequencerInst (.clk(clk), .reset(reset), .stall(stall), .instr(instr),
		.kind(kind), .condPass(condPass), .ldmReg(ldmReg), .ldmOffset(ldmOffset),
		.ldmUp(ldmUp), .ldmLast(ldmLast), .listStart(listStart), .listAdvance(listAdvance),
		.useUop(useUop), .uopStall(uopStall), .noFlagUpdate(noFlagUpdate), .keepV(keepV),
		.prevRsr(prevRsr), .ldmForward(ldmForward), .uopInstr(uopInstr), .rz(rz));

endmodule

/* sim/uopModel.svh */
// Expander reference model

`ifndef UOP_MODEL_SVH
`define UOP_MODEL_SVH

typedef struct packed {
	logic useUop;
	logic uopStall;
	logic noFlagUpdate;
	logic keepV;
	logic prevRsr;
	logic ldmForward;
	uopPkg::rzSelect rz;
	uopPkg::instrWord uopInstr;
} uopExpect;

// Odd codes invert the even code below them
function automatic logic condHolds(input logic [3:0] cond, input uopPkg::condFlags f);
	logic n, z, c, v, base;
	{n, z, c, v} = f;
	case (cond[3:1])
		3'd0: base = z;
		3'd1: base = c;
		3'd2: base = n;
		3'd3: base = v;
		3'd4: base = c && !z;
		3'd5: base = (n == v);
		3'd6: base = !z && (n == v);
		default: base = ~cond[0]; // AL passes, never code fails
	endcase
	return (cond[3:1] != 3'd7 && cond[0]) ? !base : base;
endfunction

// Expected outputs for instruction w at expansion step under flags f
function automatic uopExpect modelOutputs(input uopPkg::instrWord w, input int step,
	input uopPkg::condFlags f);
	uopExpect e;
	int count, seen, delta;
	e = '0;
	e.uopInstr = w; // Pass-through
	if (w[27:25] == 3'b000 && !w[7] && w[4] && w[27:4] != 24'h12FFF1) begin // RSR, not BX
		e.useUop = 1'b1;
		if (step == 0) begin
			e.uopStall = 1'b1;
			e.noFlagUpdate = 1'b1;
			e.rz = 4'b1100;
			e.uopInstr[24:12] = {uopPkg::opMov, 1'b0, 4'h0, uopPkg::regRz}; // MOV Rz
		end else begin
			e.prevRsr = 1'b1;
			e.rz = 4'b0010;
			e.uopInstr[11:0] = {8'h00, uopPkg::regRz};
		end
	end else if (w[27:23] == 5'b00000 && w[21] && w[7:4] == 4'b1001) begin // MLA
		e.useUop = 1'b1;
		if (step == 0) begin
			e.uopStall = 1'b1;
			e.keepV = 1'b1;
			e.rz = 4'b1100;
			e.uopInstr[21:12] = {2'b00, uopPkg::regRz, 4'h0}; // MUL Rz, no S
		end else begin
			e.prevRsr = 1'b1;
			e.rz = 4'b0001;
			e.uopInstr = '0;
			e.uopInstr[31:28] = w[31:28];
			e.uopInstr[24:12] = {uopPkg::opAdd, w[20], uopPkg::regRz, w[19:16]};
			e.uopInstr[3:0] = w[15:12]; // Accumulate operand
		end
	end else if (w[27:24] == 4'b1011) begin // BL
		e.useUop = 1'b1;
		e.uopStall = (step == 0);
		if (step == 0) begin
			e.uopInstr = '0;
			e.uopInstr[31:28] = w[31:28];
			e.uopInstr[24:21] = uopPkg::opMov;
			e.uopInstr[15:12] = uopPkg::regLink;
			e.uopInstr[3:0] = uopPkg::regPc;
		end else begin
			e.uopInstr[24] = 1'b0; // Plain branch
		end
	end else if (w[27:25] == 3'b100 && w[20] && w[15:0] != 16'h0000) begin // LDM
		count = $countones(w[15:0]);
		e.useUop = 1'b1;
		e.noFlagUpdate = 1'b1;
		e.ldmForward = (step > 0);
		e.uopInstr = '0;
		e.uopInstr[31:28] = w[31:28];
		if (step > 0 && !condHolds(w[31:28], f)) begin
			e.uopInstr[27:21] = {3'b001, uopPkg::opAdd}; // NOP ends the LDM
		end else begin
			e.uopStall = (step != count - 1);
			case (w[24:23])
				2'b00: delta = 4 - 4 * count;
				2'b01: delta = 0;
				2'b10: delta = -4 * count;
				default: delta = 4;
			endcase
			delta = delta + 4 * step;
			e.uopInstr[27:20] = {3'b010, 1'b1, delta >= 0, 3'b001};
			e.uopInstr[19:16] = w[19:16];
			e.uopInstr[11:0] = 12'(delta < 0 ? -delta : delta);
			seen = 0;
			for (int i = 0; i < 16; i++) begin // Step-th set register, ascending
				if (w[i]) begin
					if (seen == step) e.uopInstr[15:12] = 4'(i);
					seen++;
				end
			end
		end
	end
	return e;
endfunction

`endif

/* sim/uopExpanderTb.sv */
// Micro-op expander testbench

`timescale 1ns/1ps

module uopExpanderTb;

	`include "uopModel.svh"

	localparam int numInstr = 400;
	localparam int cycleLimit = numInstr * 16 * 2 + 100; // Longest LDM, stalls doubled

	logic clk, reset, stall;
	uopPkg::instrWord instr;
	uopPkg::condFlags flags;
	logic useUop, uopStall, noFlagUpdate, keepV, prevRsr, ldmForward;
	uopPkg::instrWord uopInstr;
	uopPkg::rzSelect rz;

	logic [31:0] rngState;
	int stepIdx; // Step of the held instruction
	int instrCount; // Completed instructions
	int cycleCount;
	uopExpect expNow; // Expected outputs for this cycle

	uopExpander dut (.clk(clk), .reset(reset), .instr(instr), .flags(flags), .stall(stall),
		.useUop(useUop), .uopInstr(uopInstr), .uopStall(uopStall),
		.noFlagUpdate(noFlagUpdate), .keepV(keepV), .prevRsr(prevRsr),
		.ldmForward(ldmForward), .rz(rz));

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] randWord();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// Random instruction, biased toward the four expansion kinds
	function automatic uopPkg::instrWord makeInstr();
		uopPkg::instrWord w;
		logic [31:0] pick;
		int size;
		int bitPos;
		w = randWord();
		pick = randWord();
		case (pick % 5)
			0: begin // RSR
				w[27:25] = 3'b000;
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			1: begin // MLA
				w[27:23] = 5'b00000;
				w[21] = 1'b1;
				w[7:4] = 4'b1001;
			end
			2: w[27:24] = 4'b1011; // BL
			3: begin // LDM with 1 to 16 registers
				w[27:25] = 3'b100;
				w[20] = 1'b1;
				w[15:0] = '0;
				size = 1 + int'(pick[11:8]);
				while ($countones(w[15:0]) < size) begin
					bitPos = randWord() % 16;
					w[bitPos] = 1'b1;
				end
			end
			default: ; // Raw word, usually pass-through
		endcase
		return w;
	endfunction

	task automatic checkWord(input uopPkg::instrWord got, input uopPkg::instrWord exp,
		input string name);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic checkRz(input uopPkg::rzSelect got, input uopPkg::rzSelect exp,
		input string name);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic checkCtl(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rngState = 32'd72;
		reset = 1'b1;
		stall = 1'b0;
		flags = '0;
		stepIdx = 0;
		instrCount = 0;
		cycleCount = 0;
		instr = makeInstr();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		wait (instrCount == numInstr);
		@(posedge clk);
		$display("No errors");
		$finish;
	end

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			expNow = modelOutputs(instr, stepIdx, flags);
			checkCtl(useUop, expNow.useUop, "useUop");
			checkCtl(uopStall, expNow.uopStall, "uopStall");
			checkCtl(noFlagUpdate, expNow.noFlagUpdate, "noFlagUpdate");
			checkCtl(keepV, expNow.keepV, "keepV");
			checkCtl(prevRsr, expNow.prevRsr, "prevRsr");
			checkCtl(ldmForward, expNow.ldmForward, "ldmForward");
			checkRz(rz, expNow.rz, "rz");
			checkWord(uopInstr, expNow.uopInstr, "uopInstr");
		end
	end

	// New instruction only after an unstalled final step
	always @(posedge clk) begin : drive
		logic [31:0] r;
		r = randWord();
		stall <= (r[1:0] == 2'b00); // About a quarter of the cycles
		if (!reset && !stall) begin
			if (expNow.uopStall) begin
				stepIdx <= stepIdx + 1;
			end else begin
				instr <= makeInstr();
				flags <= r[7:4];
				stepIdx <= 0;
				instrCount <= instrCount + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Errors found");
			$fatal(1, "Timeout");
		end
	end

endmodule

/* uopExpander.f */
+incdir+sim
hw/uopPkg.sv
hw/condCheck.sv
hw/uopClassify.sv
hw/ldmRegList.sv
hw/uopSequencer.sv
hw/uopExpander.sv
sim/uopExpanderTb.sv
